//--- filelist.f
src/wbm_pkg.sv
src/cas_pkg.sv
src/cmd_dispatch.sv
src/wb_cas_unit.sv
src/core_tile.sv
src/wb_rr_arbiter.sv
src/wb_sram.sv
src/mp_cas_top.sv
tests/mp_cas_chk.sv
tests/tb_mp_cas.sv

//--- run.sh
#!/bin/sh
# Compile with Verilator, run, and judge the log
set -e
cd "$(dirname "$0")"
verilator --binary --assert --top-module tb_mp_cas -f filelist.f
./obj_dir/Vtb_mp_cas +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log
if grep -qx "=== PASS ===" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi

//--- src/cas_pkg.sv
`default_nettype none

package cas_pkg;

   localparam int NUM_CORES = 4;          // Core tiles
   localparam int CORE_IDW  = 2;          // Core id width
   localparam int MEM_WORDS = 64;         // Shared memory depth
   localparam int MEM_AW    = $clog2(MEM_WORDS); // Word address width

   typedef enum logic [1:0] {
      OP_LOAD  = 2'd0,
      OP_STORE = 2'd1,
      OP_CAS   = 2'd2
   } cas_op_e;

   // One 64 bit command word, read per opcode
   typedef union packed {
      struct packed {
         logic [wbm_pkg::WB_DW-1:0] unused;  // Ignored by loads and stores
         logic [wbm_pkg::WB_DW-1:0] wdat;    // Store data
      } plain;
      struct packed {
         logic [wbm_pkg::WB_DW-1:0] cmp;     // Expected memory value
         logic [wbm_pkg::WB_DW-1:0] swp;     // Written on a match
      } cas;
   } cas_payload_u;

   typedef struct packed {
      logic [CORE_IDW-1:0] core;          // Target tile
      cas_op_e             op;
      logic [MEM_AW-1:0]   addr;          // Word address
      cas_payload_u        pay;
   } cas_cmd_t;

   typedef struct packed {
      logic [wbm_pkg::WB_DW-1:0] data;    // Read value, old value for CAS
      logic                      ok;      // CAS swapped, always set otherwise
      logic                      done;    // One cycle completion pulse
   } cas_rsp_t;

endpackage

`default_nettype wire

//--- src/cmd_dispatch.sv
`timescale 1ns/100ps
`default_nettype none

module cmd_dispatch (
   input  logic                            clk_i,
   input  logic                            arst_n_i,
   input  logic                            cmd_valid_i,
   input  cas_pkg::cas_cmd_t               cmd_i,
   input  logic [cas_pkg::NUM_CORES-1:0]   busy_i,
   output cas_pkg::cas_cmd_t               tile_cmd_o,
   output logic [cas_pkg::NUM_CORES-1:0]   tile_stb_o,
   output logic                            cmd_drop_o
);

   import cas_pkg::*;

   logic [NUM_CORES-1:0] tgt_hot;         // Decoded core id
   logic                 blocked;         // Target busy or being strobed now

   assign tgt_hot = NUM_CORES'(1) << cmd_i.core;
   assign blocked = |(tgt_hot & (busy_i | tile_stb_o));

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         tile_stb_o <= '0;
         cmd_drop_o <= 1'b0;
      end else begin
         tile_stb_o <= (cmd_valid_i && !blocked) ? tgt_hot : '0; // One cycle strobe
         cmd_drop_o <= cmd_valid_i && blocked;                   // Lost command flag
      end
   end

   // Shared command word, only the strobed tile samples it
   always_ff @(posedge clk_i) begin
      if (cmd_valid_i && !blocked) begin
         tile_cmd_o <= cmd_i;
      end
   end

endmodule

`default_nettype wire

//--- src/core_tile.sv
`timescale 1ns/100ps
`default_nettype none

module core_tile (
   input  logic              clk_i,
   input  logic              arst_n_i,
   input  logic              stb_i,
   input  cas_pkg::cas_cmd_t cmd_i,
   output logic              busy_o,
   output cas_pkg::cas_rsp_t rsp_o,
   output wbm_pkg::wb_req_t  bus_req_o,
   input  wbm_pkg::wb_rsp_t  bus_rsp_i
);

   import wbm_pkg::*;
   import cas_pkg::*;

   cas_op_e           op_q;               // Latched command
   logic [MEM_AW-1:0] addr_q;
   cas_payload_u      pay_q;
   logic              busy_q;             // Command outstanding
   logic              done_q;
   logic [WB_DW-1:0]  data_q;             // Held result
   logic              ok_q;
   wb_req_t           core_req;           // Stand-in for the CPU data port
   wb_rsp_t           core_rsp;
   logic              core_ok;

   always_ff @(posedge clk_i) begin
      if (stb_i) begin
         op_q   <= cmd_i.op;
         addr_q <= cmd_i.addr;
         pay_q  <= cmd_i.pay;
      end
      if (core_rsp.ack) begin
         data_q <= core_rsp.dat;          // Old value for CAS
         ok_q   <= core_ok;
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         busy_q <= 1'b0;
         done_q <= 1'b0;
      end else begin
         if (stb_i) busy_q <= 1'b1;
         else if (core_rsp.ack) busy_q <= 1'b0; // Falls with done
         done_q <= core_rsp.ack;
      end
   end

   // cyc and stb held from busy until the ack
   always_comb begin
      core_req     = '0;
      core_req.adr = WB_AW'(addr_q);
      if (op_q == OP_STORE) core_req.dat = pay_q.plain.wdat; // CAS data comes from the unit
      core_req.sel = 4'hf;                // Full words only
      core_req.we  = (op_q == OP_STORE);
      core_req.cyc = busy_q;
      core_req.stb = busy_q;
   end

   wb_cas_unit i_wb_cas_unit (
      .clk_i      (clk_i),
      .arst_n_i   (arst_n_i),
      .core_req_i (core_req),
      .core_op_i  (op_q),
      .core_pay_i (pay_q),
      .core_rsp_o (core_rsp),
      .core_ok_o  (core_ok),
      .bus_req_o  (bus_req_o),
      .bus_rsp_i  (bus_rsp_i)
   );

   assign busy_o = busy_q;
   assign rsp_o  = '{data: data_q, ok: ok_q, done: done_q};

endmodule

`default_nettype wire

//--- src/mp_cas_top.sv
`timescale 1ns/100ps
`default_nettype none

module mp_cas_top (
   input  logic                          clk_i,
   input  logic                          arst_n_i,
   input  logic                          cmd_valid_i,
   input  cas_pkg::cas_cmd_t             cmd_i,
   output logic                          cmd_drop_o,
   output logic [cas_pkg::NUM_CORES-1:0] busy_o,
   output cas_pkg::cas_rsp_t             rsp_o [cas_pkg::NUM_CORES]
);

   import wbm_pkg::*;
   import cas_pkg::*;

   cas_cmd_t             tile_cmd;        // Shared registered command
   logic [NUM_CORES-1:0] tile_stb;        // One-hot tile strobe
   wb_req_t              tile_req [NUM_CORES]; // Per tile data bus
   wb_rsp_t              tile_rsp [NUM_CORES];
   wb_req_t              mem_req;         // Shared bus
   wb_rsp_t              mem_rsp;

   cmd_dispatch i_cmd_dispatch (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .cmd_valid_i (cmd_valid_i),
      .cmd_i       (cmd_i),
      .busy_i      (busy_o),
      .tile_cmd_o  (tile_cmd),
      .tile_stb_o  (tile_stb),
      .cmd_drop_o  (cmd_drop_o)
   );

   for (genvar i = 0; i < NUM_CORES; i++) begin : g_tile
      core_tile i_core_tile (
         .clk_i     (clk_i),
         .arst_n_i  (arst_n_i),
         .stb_i     (tile_stb[i]),
         .cmd_i     (tile_cmd),
         .busy_o    (busy_o[i]),
         .rsp_o     (rsp_o[i]),
         .bus_req_o (tile_req[i]),
         .bus_rsp_i (tile_rsp[i])
      );
   end

   wb_rr_arbiter i_wb_rr_arbiter (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .m_req_i  (tile_req),
      .m_rsp_o  (tile_rsp),
      .s_req_o  (mem_req),
      .s_rsp_i  (mem_rsp)
   );

   wb_sram i_wb_sram (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .req_i    (mem_req),
      .rsp_o    (mem_rsp)
   );

endmodule

`default_nettype wire

//--- src/wb_cas_unit.sv
`timescale 1ns/100ps
`default_nettype none

module wb_cas_unit (
   input  logic                  clk_i,
   input  logic                  arst_n_i,
   input  wbm_pkg::wb_req_t      core_req_i,
   input  cas_pkg::cas_op_e      core_op_i,
   input  cas_pkg::cas_payload_u core_pay_i,
   output wbm_pkg::wb_rsp_t      core_rsp_o,
   output logic                  core_ok_o,
   output wbm_pkg::wb_req_t      bus_req_o,
   input  wbm_pkg::wb_rsp_t      bus_rsp_i
);

   import wbm_pkg::*;
   import cas_pkg::*;

   // Read phase runs in S_IDLE, cyc stays up through all three states
   typedef enum logic [1:0] {
      S_IDLE,
      S_GAP,
      S_WRITE
   } state_e;

   state_e           state_q;
   state_e           state_d;
   logic             is_cas;              // CAS cycle from the core
   logic             cmp_hit;             // Read data equals compare value
   logic [WB_DW-1:0] old_q;               // Value seen by the locked read

   assign is_cas  = core_req_i.cyc && (core_op_i == OP_CAS);
   assign cmp_hit = (bus_rsp_i.dat == core_pay_i.cas.cmp);

   always_comb begin
      bus_req_o  = core_req_i;            // Loads and stores pass straight
      core_rsp_o = bus_rsp_i;
      core_ok_o  = 1'b1;
      state_d    = state_q;
      if (is_cas) begin
         case (state_q)
            S_IDLE: begin
               bus_req_o.we   = 1'b0;     // Locked read
               core_rsp_o.ack = 1'b0;
               if (bus_rsp_i.ack) begin
                  if (cmp_hit) begin
                     state_d = S_GAP;
                  end else begin
                     core_rsp_o.ack = 1'b1; // Mismatch ends here
                     core_ok_o      = 1'b0;
                  end
               end
            end
            S_GAP: begin
               bus_req_o.stb  = 1'b0;     // Keep cyc, drop stb for a cycle
               core_rsp_o.ack = 1'b0;
               state_d        = S_WRITE;
            end
            S_WRITE: begin
               bus_req_o.we   = 1'b1;
               bus_req_o.dat  = core_pay_i.cas.swp;
               core_rsp_o.dat = old_q;    // Report the pre-swap value
               if (bus_rsp_i.ack) state_d = S_IDLE;
            end
            default: begin
               state_d = S_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= S_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   always_ff @(posedge clk_i) begin
      if (is_cas && (state_q == S_IDLE) && bus_rsp_i.ack) begin
         old_q <= bus_rsp_i.dat;          // Capture on read ack
      end
   end

endmodule

`default_nettype wire

//--- src/wb_rr_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module wb_rr_arbiter (
   input  logic             clk_i,
   input  logic             arst_n_i,
   input  wbm_pkg::wb_req_t m_req_i [cas_pkg::NUM_CORES],
   output wbm_pkg::wb_rsp_t m_rsp_o [cas_pkg::NUM_CORES],
   output wbm_pkg::wb_req_t s_req_o,
   input  wbm_pkg::wb_rsp_t s_rsp_i
);

   import cas_pkg::*;

   logic [NUM_CORES-1:0] grant_q;         // One-hot owner, zero when idle
   logic [CORE_IDW-1:0]  last_q;          // Current or last owner
   logic [NUM_CORES-1:0] req_vec;         // Masters with cyc up
   logic                 own_cyc;         // Owner still holds the bus
   logic                 nxt_vld;
   logic [CORE_IDW-1:0]  nxt_idx;         // Next owner after last_q

   assign own_cyc = (|grant_q) && m_req_i[last_q].cyc;

   always_comb begin
      logic [CORE_IDW-1:0] idx;
      nxt_vld = 1'b0;
      nxt_idx = last_q;
      for (int i = 0; i < NUM_CORES; i++) begin
         req_vec[i] = m_req_i[i].cyc;
      end
      // Search starts one past the last owner, wraps back to it
      for (int k = 1; k <= NUM_CORES; k++) begin
         idx = last_q + CORE_IDW'(k);
         if (!nxt_vld && req_vec[idx]) begin
            nxt_vld = 1'b1;
            nxt_idx = idx;
         end
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         grant_q <= '0;
         last_q  <= '0;
      end else if (!own_cyc) begin    // Re-arbitrate only when released
         grant_q <= nxt_vld ? (NUM_CORES'(1) << nxt_idx) : '0;
         if (nxt_vld) last_q <= nxt_idx;
      end
   end

   assign s_req_o = (|grant_q) ? m_req_i[last_q] : '0; // Idle bus when no owner

   always_comb begin
      for (int i = 0; i < NUM_CORES; i++) begin
         m_rsp_o[i].dat = s_rsp_i.dat;
         m_rsp_o[i].ack = grant_q[i] & s_rsp_i.ack; // Ack to owner only
      end
   end

endmodule

`default_nettype wire

//--- src/wb_sram.sv
`timescale 1ns/100ps
`default_nettype none

module wb_sram (
   input  logic             clk_i,
   input  logic             arst_n_i,
   input  wbm_pkg::wb_req_t req_i,
   output wbm_pkg::wb_rsp_t rsp_o
);

   import wbm_pkg::*;
   import cas_pkg::*;

   logic [WB_DW-1:0]  mem [MEM_WORDS];    // Shared words
   logic [WB_DW-1:0]  rd_q;               // Registered read data
   logic              ack_q;
   logic [MEM_AW-1:0] widx;               // Low address bits pick the word
   logic              hit;                // Accepted strobe

   assign widx = req_i.adr[MEM_AW-1:0];
   assign hit  = req_i.cyc && req_i.stb && !ack_q; // Held stb not taken twice

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= hit;
      end
   end

   always_ff @(posedge clk_i) begin
      if (hit) begin
         if (req_i.we) begin
            for (int b = 0; b < 4; b++) begin
               if (req_i.sel[b]) mem[widx][8*b +: 8] <= req_i.dat[8*b +: 8];
            end
         end
         rd_q <= mem[widx];               // Old word on a write
      end
   end

   assign rsp_o = '{dat: rd_q, ack: ack_q};

endmodule

`default_nettype wire

//--- src/wbm_pkg.sv
`default_nettype none

package wbm_pkg;

   localparam int WB_AW = 32;             // Byte or word address width
   localparam int WB_DW = 32;             // Data width

   // Master side of the shared data bus
   typedef struct packed {
      logic [WB_AW-1:0] adr;              // Word address
      logic [WB_DW-1:0] dat;              // Write data
      logic [3:0]       sel;              // Byte lanes
      logic             we;               // Write transfer
      logic             cyc;              // Cycle in progress, held for locks
      logic             stb;              // Transfer strobe
   } wb_req_t;

   // Slave side, err and rty not present
   typedef struct packed {
      logic [WB_DW-1:0] dat;              // Read data
      logic             ack;              // Single cycle termination
   } wb_rsp_t;

endpackage

`default_nettype wire

//--- tests/mp_cas_chk.sv
`timescale 1ns/100ps
`default_nettype none

module mp_cas_chk (
   input logic                          clk_i,
   input logic                          arst_n_i,
   input logic [cas_pkg::NUM_CORES-1:0] grant_i,
   input logic [cas_pkg::NUM_CORES-1:0] m_cyc_i,
   input logic                          s_cyc_i,
   input logic                          s_stb_i,
   input logic                          s_ack_i
);

   int fail_cnt = 0;                      // Failed assertions so far

   a_grant_onehot: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      $onehot0(grant_i))
      else begin
         $error("arbiter grant is not one-hot or zero");
         fail_cnt++;
      end

   // Lock held while the owner keeps cyc up
   a_grant_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (|(grant_i & m_cyc_i)) |=> $stable(grant_i))
      else begin
         $error("arbiter grant moved while the owner held cyc");
         fail_cnt++;
      end

   a_ack_after_stb: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      s_ack_i |-> $past(s_cyc_i && s_stb_i))
      else begin
         $error("memory ack without a strobe in the cycle before");
         fail_cnt++;
      end

   a_ack_in_cyc: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      s_ack_i |-> s_cyc_i)
      else begin
         $error("memory ack while the shared cyc is low");
         fail_cnt++;
      end

endmodule

`default_nettype wire

//--- tests/tb_mp_cas.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mp_cas;

   import wbm_pkg::*;
   import cas_pkg::*;

   typedef enum logic [1:0] {
      K_ONE,                              // Expected values from the table
      K_REF,                              // Expected values from ref_mem
      K_GRP,                              // Contention group member
      K_DROP                              // Sent right behind the row before
   } row_kind_e;

   typedef struct packed {
      row_kind_e        kind;
      cas_cmd_t         cmd;
      logic [WB_DW-1:0] exp_data;
      logic             exp_ok;
   } row_t;

   logic                 clk;
   logic                 arst_n;
   logic                 cmd_valid;
   cas_cmd_t             cmd;
   logic                 cmd_drop;
   logic [NUM_CORES-1:0] busy;
   cas_rsp_t             rsp [NUM_CORES];

   row_t                 rows [$];        // Stimulus table
   string                row_name [$];
   logic [WB_DW-1:0]     ref_mem [MEM_WORDS]; // Reference memory
   cas_rsp_t             got_rsp [NUM_CORES]; // Last finished response per core
   logic [NUM_CORES-1:0] busy_d;          // Busy one cycle back
   logic [1:0]           done_busy [NUM_CORES]; // Busy before and at done
   int                   done_cnt [NUM_CORES];
   int                   drop_cnt;
   int                   err_val;
   int                   err_drop;
   int                   err_busy;
   int                   err_other;
   int                   err_asrt;
   int                   cycles;
   int                   limit;           // Cycle budget for the whole table
   integer               seed;

   mp_cas_top i_mp_cas_top (
      .clk_i       (clk),
      .arst_n_i    (arst_n),
      .cmd_valid_i (cmd_valid),
      .cmd_i       (cmd),
      .cmd_drop_o  (cmd_drop),
      .busy_o      (busy),
      .rsp_o       (rsp)
   );

   bind wb_rr_arbiter mp_cas_chk i_mp_cas_chk (
      .clk_i     (clk_i),
      .arst_n_i  (arst_n_i),
      .grant_i   (grant_q),
      .m_cyc_i   (req_vec),
      .s_cyc_i   (s_req_o.cyc),
      .s_stb_i   (s_req_o.stb),
      .s_ack_i   (s_rsp_i.ack)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Outputs settle after posedge, sampled on negedge
   always @(negedge clk) begin
      for (int i = 0; i < NUM_CORES; i++) begin
         if (rsp[i].done === 1'b1) begin
            got_rsp[i]   = rsp[i];
            done_busy[i] = {busy_d[i], busy[i]};
            done_cnt[i]++;
         end
      end
      if (cmd_drop === 1'b1) drop_cnt++;
      busy_d = busy;
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= limit) begin
         $display("timeout: table not finished after %0d cycles", cycles);
         $display("=== FAIL ===");
         $finish;
      end
   end

   task automatic add_row(input row_kind_e kind, input string name, input int core,
                          input cas_op_e op, input int addr, input logic [WB_DW-1:0] a,
                          input logic [WB_DW-1:0] b, input logic [WB_DW-1:0] exp_data,
                          input logic exp_ok);
      row_t r;
      r.kind     = kind;
      r.cmd.core = CORE_IDW'(core);
      r.cmd.op   = op;
      r.cmd.addr = MEM_AW'(addr);
      if (op == OP_CAS) begin
         r.cmd.pay.cas.cmp = a;           // a is the compare value
         r.cmd.pay.cas.swp = b;
      end else begin
         r.cmd.pay.plain.unused = '0;
         r.cmd.pay.plain.wdat   = b;
      end
      r.exp_data = exp_data;
      r.exp_ok   = exp_ok;
      rows.push_back(r);
      row_name.push_back(name);
   endtask

   task automatic check_rsp(input string name, input cas_rsp_t want, input cas_rsp_t act,
                            input logic data_chk);
      if (act.ok !== want.ok || act.done !== want.done ||
          (data_chk && act.data !== want.data)) begin
         $display("error %s: expected data=%h ok=%b, actual data=%h ok=%b",
                  name, want.data, want.ok, act.data, act.ok);
         err_val++;
      end
   endtask

   task automatic check_drop(input string name, input logic want, input logic act);
      if (act !== want) begin
         $display("error %s: expected drop=%b, actual drop=%b", name, want, act);
         err_drop++;
      end
   endtask

   // Busy one cycle before done, then low in the done cycle
   task automatic check_busy(input string name, input logic [1:0] want,
                             input logic [1:0] act);
      if (act !== want) begin
         $display("error %s: expected busy before/at done=%b, actual busy=%b",
                  name, want, act);
         err_busy++;
      end
   endtask

   // Called on a negedge, leaves on the next one
   task automatic send_cmd(input cas_cmd_t c);
      cmd_valid = 1'b1;
      cmd       = c;
      @(negedge clk);
      cmd_valid = 1'b0;
   endtask

   task automatic wait_done(input int c, input int base);
      @(posedge clk);
      while (done_cnt[c] == base) @(posedge clk);
      @(negedge clk);
   endtask

   task automatic run_one(input int idx, input logic with_drop);
      row_t     r;
      int       c;
      int       base;
      int       dbase;
      cas_rsp_t want;
      r = rows[idx];
      c = int'(r.cmd.core);
      while (busy[c]) @(negedge clk);
      base  = done_cnt[c];
      dbase = drop_cnt;
      send_cmd(r.cmd);
      if (with_drop) send_cmd(rows[idx+1].cmd); // Same tile, one cycle later
      wait_done(c, base);
      want.done = 1'b1;
      if (r.kind == K_REF) begin
         want.data = ref_mem[r.cmd.addr];
         want.ok   = 1'b1;
      end else begin
         want.data = r.exp_data;
         want.ok   = r.exp_ok;
      end
      check_rsp(row_name[idx], want, got_rsp[c], r.cmd.op != OP_STORE);
      check_busy(row_name[idx], 2'b10, done_busy[c]);
      check_drop(with_drop ? row_name[idx+1] : row_name[idx], with_drop, drop_cnt != dbase);
      if (r.cmd.op == OP_STORE) begin
         ref_mem[r.cmd.addr] = r.cmd.pay.plain.wdat;
      end else if (r.cmd.op == OP_CAS && ref_mem[r.cmd.addr] == r.cmd.pay.cas.cmp) begin
         ref_mem[r.cmd.addr] = r.cmd.pay.cas.swp;
      end
      if (with_drop) begin
         repeat (8) @(negedge clk);
         if (done_cnt[c] != base + 1) begin
            $display("core %0d finished a command that was dropped", c);
            err_other++;
         end
      end
   endtask

   task automatic run_group(input int first, input int last);
      int                base [NUM_CORES];
      int                wins;
      int                win_idx;
      int                dbase;
      logic [MEM_AW-1:0] a;
      cas_rsp_t          want;
      a = rows[first].cmd.addr;
      for (int k = first; k < last; k++) begin
         while (busy[int'(rows[k].cmd.core)]) @(negedge clk);
         base[int'(rows[k].cmd.core)] = done_cnt[int'(rows[k].cmd.core)];
      end
      dbase = drop_cnt;
      for (int k = first; k < last; k++) send_cmd(rows[k].cmd); // Back to back
      for (int k = first; k < last; k++) begin
         wait_done(int'(rows[k].cmd.core), base[int'(rows[k].cmd.core)]);
      end
      wins    = 0;
      win_idx = first;
      for (int k = first; k < last; k++) begin
         if (got_rsp[int'(rows[k].cmd.core)].ok === 1'b1) begin
            wins++;
            win_idx = k;
         end
      end
      if (wins != 1) begin
         $display("contention on word %0d gave %0d winners instead of one", a, wins);
         err_other++;
      end
      // Losers ran after the winner, so they saw its swap value
      for (int k = first; k < last; k++) begin
         want.done = 1'b1;
         want.ok   = (k == win_idx);
         want.data = (k == win_idx) ? ref_mem[a] : rows[win_idx].cmd.pay.cas.swp;
         check_rsp(row_name[k], want, got_rsp[int'(rows[k].cmd.core)], 1'b1);
         check_busy(row_name[k], 2'b10, done_busy[int'(rows[k].cmd.core)]);
      end
      check_drop(row_name[first], 1'b0, drop_cnt != dbase);
      ref_mem[a] = rows[win_idx].cmd.pay.cas.swp;
   endtask

   initial begin
      int               i;
      int               j;
      logic [WB_DW-1:0] rnd;
      seed      = 32'h8649;
      arst_n    = 1'b0;
      cmd_valid = 1'b0;
      cmd       = '0;
      drop_cnt  = 0;
      err_val   = 0;
      err_drop  = 0;
      err_busy  = 0;
      err_other = 0;
      err_asrt  = 0;
      cycles    = 0;
      for (int k = 0; k < NUM_CORES; k++) done_cnt[k] = 0;

      add_row(K_ONE, "st_c0", 0, OP_STORE, 3, '0, 32'hA5A5_0003, '0, 1'b1);
      add_row(K_ONE, "st_c1", 1, OP_STORE, 17, '0, 32'h1234_5678, '0, 1'b1);
      add_row(K_ONE, "st_c2", 2, OP_STORE, 40, '0, 32'hDEAD_BEEF, '0, 1'b1);
      add_row(K_ONE, "st_c3", 3, OP_STORE, 63, '0, 32'h0BAD_F00D, '0, 1'b1);
      add_row(K_ONE, "ld_c2", 2, OP_LOAD, 3, '0, '0, 32'hA5A5_0003, 1'b1); // Other cores read
      add_row(K_ONE, "ld_c3", 3, OP_LOAD, 17, '0, '0, 32'h1234_5678, 1'b1);
      add_row(K_ONE, "ld_c0", 0, OP_LOAD, 40, '0, '0, 32'hDEAD_BEEF, 1'b1);
      add_row(K_ONE, "ld_c1", 1, OP_LOAD, 63, '0, '0, 32'h0BAD_F00D, 1'b1);
      add_row(K_ONE, "cas_hit", 1, OP_CAS, 17, 32'h1234_5678, 32'hCAFE_0001,
              32'h1234_5678, 1'b1);
      add_row(K_ONE, "ld_after_hit", 2, OP_LOAD, 17, '0, '0, 32'hCAFE_0001, 1'b1);
      add_row(K_ONE, "cas_miss", 3, OP_CAS, 40, 32'h0, 32'h1111_1111, 32'hDEAD_BEEF, 1'b0);
      add_row(K_ONE, "ld_after_miss", 0, OP_LOAD, 40, '0, '0, 32'hDEAD_BEEF, 1'b1);
      add_row(K_ONE, "st_lock", 0, OP_STORE, 20, '0, 32'h0000_0C0C, '0, 1'b1);
      for (int k = 0; k < NUM_CORES; k++) begin
         add_row(K_GRP, $sformatf("grp_c%0d", k), k, OP_CAS, 20, 32'h0000_0C0C,
                 32'h0000_1000 + k, '0, 1'b0);
      end
      add_row(K_REF, "ld_after_grp", 2, OP_LOAD, 20, '0, '0, '0, 1'b1);
      add_row(K_ONE, "st_first", 1, OP_STORE, 50, '0, 32'h5555_AAAA, '0, 1'b1);
      add_row(K_DROP, "st_dropped", 1, OP_STORE, 50, '0, 32'hFFFF_0000, '0, 1'b1);
      add_row(K_ONE, "ld_after_drop", 3, OP_LOAD, 50, '0, '0, 32'h5555_AAAA, 1'b1);
      for (int k = 0; k < 8; k++) begin
         rnd = $random(seed);             // Fill words 8..15 first
         add_row(K_REF, $sformatf("rnd_st_%0d", k), k % NUM_CORES, OP_STORE, 8 + k,
                 '0, rnd, '0, 1'b1);
      end
      for (int k = 0; k < 16; k++) begin
         rnd = $random(seed);
         add_row(K_REF, $sformatf("rnd_%0d", k), int'(rnd[1:0]),
                 rnd[2] ? OP_STORE : OP_LOAD, 8 + int'(rnd[5:3]), '0, $random(seed),
                 '0, 1'b1);
      end
      limit = rows.size() * 40;

      repeat (5) @(negedge clk);
      arst_n = 1'b1;
      @(negedge clk);

      i = 0;
      while (i < rows.size()) begin
         if (rows[i].kind == K_GRP) begin
            j = i;
            while (j < rows.size() && rows[j].kind == K_GRP) j++;
            run_group(i, j);
            i = j;
         end else if (i + 1 < rows.size() && rows[i+1].kind == K_DROP) begin
            run_one(i, 1'b1);
            i = i + 2;
         end else begin
            run_one(i, 1'b0);
            i++;
         end
      end

      err_asrt = i_mp_cas_top.i_wb_rr_arbiter.i_mp_cas_chk.fail_cnt;
      $display("errors: %0d value, %0d drop, %0d busy, %0d other, %0d assertion",
               err_val, err_drop, err_busy, err_other, err_asrt);
      if (err_val + err_drop + err_busy + err_other + err_asrt == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

`default_nettype wire
